/* source/host_pkg.sv */
// ********************
// Shared widths, L2 geometry, config register map and the host address
// views. Modules take it with a wildcard import in their header.
// ********************
package host_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // L2 scratchpad geometry
  localparam int unsigned NUM_BANKS_DEF  = 8;
  localparam int unsigned BANK_WORDS_DEF = 1024;
  localparam int unsigned BANK_SEL_W     = $clog2(NUM_BANKS_DEF);
  localparam int unsigned ROW_W          = $clog2(BANK_WORDS_DEF);

  // Address bit 16 set selects config space
  localparam int unsigned REGION_BIT = 16;

  localparam int unsigned CFG_IDX_W = 4;

  localparam logic [CFG_IDX_W-1:0] CFG_CACHE_START = 4'd0;
  localparam logic [CFG_IDX_W-1:0] CFG_CACHE_END   = 4'd1;
  localparam logic [CFG_IDX_W-1:0] CFG_SPM_START   = 4'd2;
  localparam logic [CFG_IDX_W-1:0] CFG_DMA_EVT_CNT = 4'd3;

  // Returned for any index without a register behind it
  localparam logic [DATA_W-1:0] CFG_DEFAULT_RDATA = 32'hDEAD_F000;

  // L2 view, word interleaved across the banks
  typedef struct packed {
    logic [ADDR_W-REGION_BIT-2:0]                unused_hi;
    logic                                        region;
    logic [REGION_BIT-ROW_W-BANK_SEL_W-3:0]      unused_mid;
    logic [ROW_W-1:0]                            row;
    logic [BANK_SEL_W-1:0]                       bank;
    logic [1:0]                                  byte_off;
  } l2_addr_t;

  // Config view, one register per word
  typedef struct packed {
    logic [ADDR_W-REGION_BIT-2:0]                unused_hi;
    logic                                        region;
    logic [REGION_BIT-CFG_IDX_W-3:0]             unused_mid;
    logic [CFG_IDX_W-1:0]                        idx;
    logic [1:0]                                  byte_off;
  } cfg_addr_t;

  typedef union packed {
    l2_addr_t  l2;
    cfg_addr_t cfg;
  } host_addr_u;

endpackage

/* source/dma_evt_sync.sv */
// ********************
// Receive side of the cluster DMA event handshake.
// Acknowledges the synchronized level and pulses once per event.
// ********************
`timescale 1ns/100ps

module dma_evt_sync import host_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic dma_evt_valid_i,
  output logic dma_evt_ack_o,
  output logic dma_evt_pulse_o
);

  logic [1:0] sync_q;
  logic       prev_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
      prev_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], dma_evt_valid_i};
      prev_q <= sync_q[1];
    end
  end

  // Ack follows the request level two cycles later
  assign dma_evt_ack_o = sync_q[1];

  // Rising edge of the synchronized level
  assign dma_evt_pulse_o = sync_q[1] & ~prev_q;

endmodule

/* source/l2_mem_banks.sv */
// ********************
// Word-interleaved L2 scratchpad. Consecutive words land in consecutive
// banks; one request per cycle, read data registered.
// ********************
`timescale 1ns/100ps

module l2_mem_banks import host_pkg::*; #(
  parameter int unsigned NUM_BANKS  = NUM_BANKS_DEF,
  parameter int unsigned BANK_WORDS = BANK_WORDS_DEF
) (
  input  logic              clk_i,
  input  logic              req_i,
  input  logic              write_i,
  input  host_addr_u        addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic [DATA_W-1:0] rdata_o
);

  localparam int unsigned SEL_W  = $clog2(NUM_BANKS);
  localparam int unsigned ROWS_W = $clog2(BANK_WORDS);

  logic [SEL_W-1:0]  bank_sel;
  logic [ROWS_W-1:0] row_sel;
  logic [DATA_W-1:0] bank_rdata [NUM_BANKS];

  // Bank from the low word bits, row from the bits above
  assign bank_sel = addr_i.l2.bank[SEL_W-1:0];
  assign row_sel  = addr_i.l2.row[ROWS_W-1:0];

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    localparam logic [SEL_W-1:0] BANK_ID = SEL_W'(b);

    logic [DATA_W-1:0] mem_q [BANK_WORDS];

    always_ff @(posedge clk_i) begin
      if (req_i && write_i && (bank_sel == BANK_ID)) begin
        mem_q[row_sel] <= wdata_i;
      end
    end

    assign bank_rdata[b] = mem_q[row_sel];
  end

  // Single registered read port, zero on writes
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (write_i) begin
        rdata_o <= '0;
      end else begin
        rdata_o <= bank_rdata[bank_sel];
      end
    end
  end

endmodule

/* source/host_cfg_regs.sv */
// ********************
// Cache window registers and the read-only DMA event counter.
// Unmapped indices read back the default word.
// ********************
`timescale 1ns/100ps

module host_cfg_regs import host_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_i,
  input  logic              write_i,
  input  host_addr_u        addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic [DATA_W-1:0] rdata_o,
  input  logic              dma_evt_pulse_i
);

  logic [CFG_IDX_W-1:0] reg_idx;
  logic [DATA_W-1:0]    cache_start_q;
  logic [DATA_W-1:0]    cache_end_q;
  logic [DATA_W-1:0]    spm_start_q;
  logic [DATA_W-1:0]    dma_evt_cnt_q;
  logic [DATA_W-1:0]    rd_word;

  assign reg_idx = addr_i.cfg.idx;

  // Window registers, writes elsewhere are dropped
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cache_start_q <= '0;
      cache_end_q   <= '0;
      spm_start_q   <= '0;
    end else if (req_i && write_i) begin
      case (reg_idx)
        CFG_CACHE_START: cache_start_q <= wdata_i;
        CFG_CACHE_END:   cache_end_q   <= wdata_i;
        CFG_SPM_START:   spm_start_q   <= wdata_i;
        default: ;
      endcase
    end
  end

  // Wraps at the top
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dma_evt_cnt_q <= '0;
    end else if (dma_evt_pulse_i) begin
      dma_evt_cnt_q <= dma_evt_cnt_q + 1'b1;
    end
  end

  always_comb begin
    case (reg_idx)
      CFG_CACHE_START: rd_word = cache_start_q;
      CFG_CACHE_END:   rd_word = cache_end_q;
      CFG_SPM_START:   rd_word = spm_start_q;
      CFG_DMA_EVT_CNT: rd_word = dma_evt_cnt_q;
      default:         rd_word = CFG_DEFAULT_RDATA;
    endcase
  end

  // Held until the next request
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rdata_o <= '0;
    end else if (req_i) begin
      rdata_o <= write_i ? '0 : rd_word;
    end
  end

endmodule

/* source/host_xbar.sv */
// ********************
// Routes each accepted host request to L2 or config space and returns
// the selected target's read data. One transaction in flight at a time.
// ********************
`timescale 1ns/100ps

module host_xbar import host_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Host side
  input  logic              req_valid_i,
  input  logic              req_write_i,
  input  host_addr_u        req_addr_i,
  input  logic [DATA_W-1:0] req_wdata_i,
  output logic              req_ready_o,
  output logic              rsp_valid_o,
  output logic [DATA_W-1:0] rsp_rdata_o,
  input  logic              rsp_ready_i,
  // Target side
  output logic              l2_req_o,
  output logic              cfg_req_o,
  output logic              tgt_write_o,
  output host_addr_u        tgt_addr_o,
  output logic [DATA_W-1:0] tgt_wdata_o,
  input  logic [DATA_W-1:0] l2_rdata_i,
  input  logic [DATA_W-1:0] cfg_rdata_i
);

  logic rsp_pending_q;
  logic sel_cfg_q;
  logic accept;
  logic hit_cfg;

  // Free when idle or when the pending response leaves this cycle
  assign req_ready_o = ~rsp_pending_q | rsp_ready_i;
  assign accept      = req_valid_i & req_ready_o;

  assign hit_cfg = req_addr_i[REGION_BIT];

  // Exactly one strobe per accepted request
  assign l2_req_o  = accept & ~hit_cfg;
  assign cfg_req_o = accept & hit_cfg;

  assign tgt_write_o = req_write_i;
  assign tgt_addr_o  = req_addr_i;
  assign tgt_wdata_o = req_wdata_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_pending_q <= 1'b0;
    end else if (accept) begin
      rsp_pending_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_pending_q <= 1'b0;
    end
  end

  // Remember the target so the returning data can be picked
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sel_cfg_q <= 1'b0;
    end else if (accept) begin
      sel_cfg_q <= hit_cfg;
    end
  end

  // Targets hold their data until the next strobe, so this stays stable
  // while the host stalls
  assign rsp_valid_o = rsp_pending_q;
  assign rsp_rdata_o = sel_cfg_q ? cfg_rdata_i : l2_rdata_i;

endmodule

/* source/host_domain.sv */
// ********************
// Host domain top level. Joins the request crossbar, the L2 banks,
// the cache window registers and the cluster DMA event receiver.
// ********************
`timescale 1ns/100ps

module host_domain import host_pkg::*; #(
  parameter int unsigned NUM_BANKS  = NUM_BANKS_DEF,
  parameter int unsigned BANK_WORDS = BANK_WORDS_DEF
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Host request
  input  logic              req_valid_i,
  input  logic              req_write_i,
  input  host_addr_u        req_addr_i,
  input  logic [DATA_W-1:0] req_wdata_i,
  output logic              req_ready_o,
  // Host response
  output logic              rsp_valid_o,
  output logic [DATA_W-1:0] rsp_rdata_o,
  input  logic              rsp_ready_i,
  // Cluster DMA event
  input  logic              dma_evt_valid_i,
  output logic              dma_evt_ack_o
);

  logic              l2_req;
  logic              cfg_req;
  logic              tgt_write;
  host_addr_u        tgt_addr;
  logic [DATA_W-1:0] tgt_wdata;
  logic [DATA_W-1:0] l2_rdata;
  logic [DATA_W-1:0] cfg_rdata;
  logic              dma_evt_pulse;

  host_xbar u_xbar (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .req_valid_i ( req_valid_i ),
    .req_write_i ( req_write_i ),
    .req_addr_i  ( req_addr_i  ),
    .req_wdata_i ( req_wdata_i ),
    .req_ready_o ( req_ready_o ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_rdata_o ( rsp_rdata_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .l2_req_o    ( l2_req      ),
    .cfg_req_o   ( cfg_req     ),
    .tgt_write_o ( tgt_write   ),
    .tgt_addr_o  ( tgt_addr    ),
    .tgt_wdata_o ( tgt_wdata   ),
    .l2_rdata_i  ( l2_rdata    ),
    .cfg_rdata_i ( cfg_rdata   )
  );

  l2_mem_banks #(
    .NUM_BANKS  ( NUM_BANKS  ),
    .BANK_WORDS ( BANK_WORDS )
  ) u_l2 (
    .clk_i   ( clk_i     ),
    .req_i   ( l2_req    ),
    .write_i ( tgt_write ),
    .addr_i  ( tgt_addr  ),
    .wdata_i ( tgt_wdata ),
    .rdata_o ( l2_rdata  )
  );

  host_cfg_regs u_cfg (
    .clk_i           ( clk_i         ),
    .rst_n_i         ( rst_n_i       ),
    .req_i           ( cfg_req       ),
    .write_i         ( tgt_write     ),
    .addr_i          ( tgt_addr      ),
    .wdata_i         ( tgt_wdata     ),
    .rdata_o         ( cfg_rdata     ),
    .dma_evt_pulse_i ( dma_evt_pulse )
  );

  dma_evt_sync u_dma_evt (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .dma_evt_valid_i ( dma_evt_valid_i ),
    .dma_evt_ack_o   ( dma_evt_ack_o   ),
    .dma_evt_pulse_o ( dma_evt_pulse   )
  );

endmodule

/* sim/tb_host_domain.sv */
// ********************
// Testbench for the host domain. Replays the test data file through the
// host port under random back-pressure and drives cluster DMA events.
// ********************
`timescale 1ns/100ps

module tb_host_domain;

  localparam int          CLK_PERIOD = 10;
  localparam int          RST_CYCLES = 3;
  localparam int          CYC_PER_OP = 40;
  localparam logic [31:0] SEED       = 32'h523aca1b;
  localparam string       DATA_FILE  = "sim/host_testdata.txt";

  logic        clk = 1'b0;
  logic        rst_n;
  logic        req_valid;
  logic        req_write;
  logic [31:0] req_addr;
  logic [31:0] req_wdata;
  logic        req_ready;
  logic        rsp_valid;
  logic [31:0] rsp_rdata;
  logic        rsp_ready = 1'b0;
  logic        dma_evt_valid;
  logic        dma_evt_ack;

  int          t_num[$];
  logic [7:0]  op_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [31:0] exp_q[$];

  bit          loaded = 1'b0;
  int          err_count = 0;
  int          check_count = 0;
  int          test_errs = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          n_accepted = 0;
  int          n_responses = 0;

  host_domain u_host_domain (
    .clk_i           ( clk           ),
    .rst_n_i         ( rst_n         ),
    .req_valid_i     ( req_valid     ),
    .req_write_i     ( req_write     ),
    .req_addr_i      ( req_addr      ),
    .req_wdata_i     ( req_wdata     ),
    .req_ready_o     ( req_ready     ),
    .rsp_valid_o     ( rsp_valid     ),
    .rsp_rdata_o     ( rsp_rdata     ),
    .rsp_ready_i     ( rsp_ready     ),
    .dma_evt_valid_i ( dma_evt_valid ),
    .dma_evt_ack_o   ( dma_evt_ack   )
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  // Random stalls on about one response cycle in four
  always @(posedge clk) begin
    #1;
    rsp_ready = ($urandom % 4) != 0;
  end

  // Handshake counters sampled on the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (req_valid && req_ready) n_accepted = n_accepted + 1;
      if (rsp_valid && rsp_ready) n_responses = n_responses + 1;
    end
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    check_count = check_count + 1;
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      err_count = err_count + 1;
      test_errs = test_errs + 1;
    end
  endtask

  task automatic load_testdata();
    int          fd;
    int          got;
    int          tn;
    string       line;
    logic [7:0]  oc;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("Error: cannot open the test data file %s", DATA_FILE);
      err_count = err_count + 1;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        got = $sscanf(line, "%d %c %h %h %h", tn, oc, a, d, e);
        if (got == 5) begin
          t_num.push_back(tn);
          op_q.push_back(oc);
          addr_q.push_back(a);
          data_q.push_back(d);
          exp_q.push_back(e);
        end else begin
          $display("Error: malformed test data line: %s", line);
          err_count = err_count + 1;
        end
      end
    end
    $fclose(fd);
  endtask

  // Issue one request and watch its response while stalled
  task automatic host_access(input logic wr, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    logic [31:0] held;
    bit          taken;
    @(posedge clk);
    #1;
    req_valid = 1'b1;
    req_write = wr;
    req_addr  = addr;
    req_wdata = wdata;
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    @(negedge clk);
    compare_value("rsp_valid_o", {31'b0, rsp_valid}, 32'h1);
    held  = rsp_rdata;
    taken = 1'b0;
    while (!taken) begin
      if (!rsp_valid) begin
        $display("Error: response withdrawn before the host took it");
        err_count = err_count + 1;
        test_errs = test_errs + 1;
        taken = 1'b1;
      end else begin
        compare_value("rsp_rdata_o", rsp_rdata, held);
        if (rsp_ready) taken = 1'b1;
        else @(negedge clk);
      end
    end
    rdata = held;
    @(negedge clk);
    compare_value("rsp_valid_o", {31'b0, rsp_valid}, 32'h0);
  endtask

  // Full four-phase handshakes on the cluster event port
  task automatic run_events(input logic [31:0] count);
    int cycles;
    for (int n = 0; n < int'(count); n++) begin
      @(posedge clk);
      #1;
      dma_evt_valid = 1'b1;
      cycles = 0;
      // Valid is first sampled on the edge after this falling edge
      @(negedge clk);
      while (!dma_evt_ack) begin
        @(negedge clk);
        cycles = cycles + 1;
      end
      compare_value("dma_evt_ack_o delay", cycles, 32'd2);
      @(posedge clk);
      #1;
      dma_evt_valid = 1'b0;
      do @(negedge clk); while (dma_evt_ack);
    end
  endtask

  task automatic report_test(input int t);
    tests_run = tests_run + 1;
    if (test_errs != 0) tests_failed = tests_failed + 1;
    $display("Test %0d finished with %0d errors", t, test_errs);
    test_errs = 0;
  endtask

  initial begin
    logic [31:0] rd;
    int          cur_test;
    void'($urandom(SEED));
    rst_n         = 1'b0;
    req_valid     = 1'b0;
    req_write     = 1'b0;
    req_addr      = '0;
    req_wdata     = '0;
    dma_evt_valid = 1'b0;
    load_testdata();
    loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    compare_value("req_ready_o", {31'b0, req_ready}, 32'h1);
    compare_value("rsp_valid_o", {31'b0, rsp_valid}, 32'h0);
    compare_value("dma_evt_ack_o", {31'b0, dma_evt_ack}, 32'h0);
    if (t_num.size() > 0) begin
      cur_test = t_num[0];
      for (int i = 0; i < t_num.size(); i++) begin
        if (t_num[i] != cur_test) begin
          report_test(cur_test);
          cur_test = t_num[i];
        end
        case (op_q[i])
          "W": begin
            host_access(1'b1, addr_q[i], data_q[i], rd);
            compare_value("rsp_rdata_o", rd, exp_q[i]);
          end
          "R": begin
            host_access(1'b0, addr_q[i], '0, rd);
            compare_value("rsp_rdata_o", rd, exp_q[i]);
          end
          "E": run_events(data_q[i]);
          default: begin
            $display("Error: unknown operation on test data line %0d", i + 1);
            err_count = err_count + 1;
            test_errs = test_errs + 1;
          end
        endcase
      end
      report_test(cur_test);
    end
    compare_value("rsp_valid_o handshakes", n_responses, n_accepted);
    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, err_count);
    if (err_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Limit scales with the number of data lines
  initial begin
    wait (loaded);
    repeat (RST_CYCLES + 10 + t_num.size() * CYC_PER_OP) @(posedge clk);
    $display("Timeout: the tests did not finish in the allowed time");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* host_domain.f */
source/host_pkg.sv
source/dma_evt_sync.sv
source/l2_mem_banks.sv
source/host_cfg_regs.sv
source/host_xbar.sv
source/host_domain.sv
sim/tb_host_domain.sv

/* Makefile */
# Verilator build and run for the host domain testbench
VERILATOR ?= verilator
TOP       ?= tb_host_domain
FILELIST  ?= host_domain.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/host_testdata.txt */
# test op(W/R/E) address(hex) wdata-or-event-count(hex) expected-rdata(hex)
# Writes expect zero read data; E lines run that many event handshakes
1 W 00000000 A0000000 00000000
1 W 00000004 A1000001 00000000
1 W 00000008 A2000002 00000000
1 W 0000000C A3000003 00000000
1 W 00000010 A4000004 00000000
1 W 00000014 A5000005 00000000
1 W 00000018 A6000006 00000000
1 W 0000001C A7000007 00000000
1 W 00007FE0 B0FF03E0 00000000
1 W 00007FFC B7FF03FF 00000000
1 R 00000000 00000000 A0000000
1 R 00000004 00000000 A1000001
1 R 00000008 00000000 A2000002
1 R 0000000C 00000000 A3000003
1 R 00000010 00000000 A4000004
1 R 00000014 00000000 A5000005
1 R 00000018 00000000 A6000006
1 R 0000001C 00000000 A7000007
1 R 00007FE0 00000000 B0FF03E0
1 R 00007FFC 00000000 B7FF03FF
2 R 00010000 00000000 00000000
2 R 00010004 00000000 00000000
2 R 00010008 00000000 00000000
2 W 00010000 80000000 00000000
2 W 00010004 8FFFFFFF 00000000
2 W 00010008 1C000000 00000000
2 R 00010000 00000000 80000000
2 R 00010004 00000000 8FFFFFFF
2 R 00010008 00000000 1C000000
3 R 00010010 00000000 DEADF000
3 R 0001003C 00000000 DEADF000
3 W 00010010 12345678 00000000
3 R 00010010 00000000 DEADF000
3 W 0001000C FFFFFFFF 00000000
3 R 0001000C 00000000 00000000
4 E 00000000 00000001 00000000
4 R 0001000C 00000000 00000001
4 E 00000000 00000003 00000000
4 R 0001000C 00000000 00000004
4 R 00010004 00000000 8FFFFFFF
